//--- verilog.f
hw/lsu_pkg.sv
hw/ls_request_stage.sv
hw/load_attr_fifo.sv
hw/scratch_mem.sv
hw/bus_port.sv
hw/load_return.sv
hw/lsu_top.sv
verif/lsu_tb.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module lsu_tb -f verilog.f \
		--Mdir obj_dir -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/lsu_tb.sv
//////////////////////////////
// Testbench for the load/store unit.
// LFSR stimulus drives issue and writeback ack, a responder serves
// the bus from a byte memory, and a model predicts every result.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam logic [31:0] SCR_BASE  = 32'h0000_0100;
    localparam logic [31:0] BUS_BASE  = 32'h8000_0040;
    localparam logic [31:0] TAPS      = 32'h8020_0003;
    localparam int          MAX_LAT   = 4;
    localparam int          MAX_GAP   = 7;
    localparam int          TOTAL_OPS = 236;
    localparam int          LIMIT     = TOTAL_OPS * (MAX_LAT + MAX_GAP + 4) + 200;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    ls_issue_t issue;
    logic issue_ready;
    exception_t ls_exception;
    logic store_complete;
    id_t store_id;
    logic wb_done;
    logic [31:0] wb_data;
    id_t wb_id;
    logic wb_ack;
    logic bus_req;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0] bus_be;
    logic bus_rnw;
    logic bus_ack;
    logic [31:0] bus_rdata;

    // Model state
    logic [7:0]  scr_mem [64];
    logic [7:0]  bus_mem [64];
    logic [31:0] exp_data [$];
    id_t         exp_id [$];
    logic [31:0] mis_words [$];
    logic [31:0] lfsr = 32'd28;
    ls_issue_t   op;
    logic [31:0] op_addr;
    logic        have_op;
    id_t         next_id;
    logic [31:0] exp_bus_addr;
    logic [3:0]  exp_be;
    logic [31:0] exp_wdata;
    logic        exp_rnw;
    logic        bus_outstanding;
    logic        bus_req_due;
    logic [31:0] bus_word;
    int          bus_lat;
    int          gap_left;
    int          gap_bits;
    logic        held;
    logic [31:0] held_data;
    id_t         held_id;
    int          cycles;
    int          errors;
    int          errs_at_start;
    int          tests_passed;
    int          tests_failed;
    string       test_name;

    lsu_top #(
        .SCRATCH_WORDS(256),
        .ATTR_DEPTH(2)
    ) i_dut (
        .clk, .rst, .issue_valid, .issue, .issue_ready, .ls_exception,
        .store_complete, .store_id, .wb_done, .wb_data, .wb_id, .wb_ack,
        .bus_req, .bus_addr, .bus_wdata, .bus_be, .bus_rnw, .bus_ack, .bus_rdata
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ TAPS) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic int width_of(input logic [2:0] fn3);
        if (fn3[1:0] == 2'b00) begin
            return 1;
        end
        return (fn3[1:0] == 2'b01) ? 2 : 4;
    endfunction

    function automatic logic [7:0] read_byte(input logic [31:0] a);
        return (a[31:28] == 4'h0) ? scr_mem[a - SCR_BASE] : bus_mem[a - BUS_BASE];
    endfunction

    task automatic write_byte(input logic [31:0] a, input logic [7:0] b);
        if (a[31:28] == 4'h0) begin
            scr_mem[a - SCR_BASE] = b;
        end else begin
            bus_mem[a - BUS_BASE] = b;
        end
    endtask

    // Expected load value gathered byte by byte from the model
    function automatic logic [31:0] load_value(input logic [2:0] fn3, input logic [31:0] a);
        logic [31:0] v;
        int n;
        n = width_of(fn3);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = read_byte(a + i);
        end
        if (fn3 == LS_B && v[7]) begin
            v[31:8] = '1;
        end
        if (fn3 == LS_H && v[15]) begin
            v[31:16] = '1;
        end
        return v;
    endfunction

    task automatic accept_op();
        int n;
        logic bad;
        n = width_of(op.fn3);
        bad = (n == 2 && op_addr[0]) || (n == 4 && op_addr[1:0] != 2'b00);
        if (bad) begin
            compare({test_name, " exc_valid"}, 1, ls_exception.valid);
            compare({test_name, " exc_code"}, op.store ? STORE_MISALIGNED : LOAD_MISALIGNED,
                    ls_exception.code);
            compare({test_name, " exc_tval"}, op_addr, ls_exception.tval);
            compare({test_name, " exc_id"}, op.id, ls_exception.id);
            compare({test_name, " store_complete"}, 0, store_complete);
        end else begin
            compare({test_name, " exc_valid"}, 0, ls_exception.valid);
            compare({test_name, " store_complete"}, op.store, store_complete);
            exp_be = '0;
            if (op.store) begin
                compare({test_name, " store_id"}, op.id, store_id);
                for (int i = 0; i < n; i++) begin
                    write_byte(op_addr + i, op.rs2[8*i +: 8]);
                    exp_be[op_addr[1:0] + i] = 1'b1;
                    exp_wdata[8*(op_addr[1:0] + i) +: 8] = op.rs2[8*i +: 8];
                end
            end else begin
                exp_data.push_back(load_value(op.fn3, op_addr));
                exp_id.push_back(op.id);
            end
            if (op_addr[31:28] != 4'h0) begin
                bus_outstanding = 1'b1;
                bus_req_due = 1'b1;
                exp_bus_addr = op_addr;
                exp_rnw = op.load;
            end
        end
        have_op = 1'b0;
    endtask

    // One clock cycle of bus responder, writeback and issue
    task automatic step();
        int idx;
        @(negedge clk);
        bus_ack = 1'b0;
        if (bus_lat > 0) begin
            compare({test_name, " held bus_addr"}, exp_bus_addr, bus_addr);
            bus_lat--;
            if (bus_lat == 0) begin
                idx = bus_word - BUS_BASE;
                bus_rdata = {bus_mem[idx+3], bus_mem[idx+2], bus_mem[idx+1], bus_mem[idx]};
                bus_ack = 1'b1;
                bus_outstanding = 1'b0;
            end
        end
        if (bus_req) begin
            if (!bus_req_due) begin
                errors++;
                $display("%s: bus request sent with no bus access accepted", test_name);
            end
            bus_req_due = 1'b0;
            compare({test_name, " bus_addr"}, exp_bus_addr, bus_addr);
            compare({test_name, " bus_be"}, exp_be, bus_be);
            compare({test_name, " bus_rnw"}, exp_rnw, bus_rnw);
            for (int i = 0; i < 4; i++) begin
                if (exp_be[i]) begin
                    compare({test_name, " bus_wdata"}, exp_wdata[8*i +: 8], bus_wdata[8*i +: 8]);
                end
            end
            bus_word = {bus_addr[31:2], 2'b00};
            bus_lat = 1 + rand_bits(2);
        end
        wb_ack = 1'b0;
        #1;
        if (wb_done) begin
            if (held) begin
                compare({test_name, " held wb_data"}, held_data, wb_data);
                compare({test_name, " held wb_id"}, held_id, wb_id);
            end
            if (exp_data.size() == 0) begin
                errors++;
                $display("%s: writeback result appeared with no load outstanding", test_name);
                wb_ack = 1'b1;
                held = 1'b0;
            end else if (gap_left == 0) begin
                compare({test_name, " wb_data"}, exp_data.pop_front(), wb_data);
                compare({test_name, " wb_id"}, exp_id.pop_front(), wb_id);
                wb_ack = 1'b1;
                held = 1'b0;
                gap_left = rand_bits(gap_bits);
            end else begin
                gap_left--;
                held = 1'b1;
                held_data = wb_data;
                held_id = wb_id;
            end
        end else begin
            held = 1'b0;
        end
        issue_valid = have_op;
        issue = op;
        #1;
        if (have_op && issue_ready) begin
            accept_op();
        end else begin
            compare({test_name, " idle store_complete"}, 0, store_complete);
            compare({test_name, " idle exc_valid"}, 0, ls_exception.valid);
        end
    endtask

    task automatic issue_op(input logic is_load, input logic [2:0] fn3,
                            input logic [31:0] addr, input logic [31:0] data);
        logic [11:0] off;
        off = rand_bits(12);
        op.offset = off;
        op.rs1 = addr - {{20{off[11]}}, off};
        op.rs2 = data;
        op.fn3 = fn3;
        op.load = is_load;
        op.store = !is_load;
        op.id = next_id;
        next_id++;
        op_addr = addr;
        have_op = 1'b1;
        while (have_op) begin
            step();
        end
    endtask

    // unit 0 is scratch, 1 bus, 2 either. kind 0 is load, 1 store, 2 either
    task automatic issue_random(input int unit, input int kind);
        logic is_load;
        logic [2:0] fn3;
        logic [31:0] base;
        logic [5:0] off;
        is_load = (kind == 2) ? rand_bits(1) : (kind == 0);
        case (rand_bits(3) % 5)
            0: fn3 = LS_B;
            1: fn3 = LS_H;
            2: fn3 = LS_W;
            3: fn3 = is_load ? L_BU : LS_B;
            default: fn3 = is_load ? L_HU : LS_H;
        endcase
        base = ((unit == 2) ? rand_bits(1) : unit) ? BUS_BASE : SCR_BASE;
        off = rand_bits(6) & ~(width_of(fn3) - 1);
        issue_op(is_load, fn3, base + off, rand_bits(32));
    endtask

    task automatic begin_test(input string name, input int gaps);
        test_name = name;
        gap_bits = gaps;
        errs_at_start = errors;
    endtask

    task automatic finish_test();
        while (exp_data.size() > 0 || bus_outstanding || have_op) begin
            step();
        end
        repeat (2) step();
        if (errors == errs_at_start) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - errs_at_start);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [2:0] fns [5];
        fns = '{LS_B, LS_H, LS_W, L_BU, L_HU};
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        wb_ack = 1'b0;
        bus_ack = 1'b0;
        bus_rdata = '0;
        op = '0;
        have_op = 1'b0;
        next_id = '0;
        bus_outstanding = 1'b0;
        bus_req_due = 1'b0;
        bus_lat = 0;
        gap_left = 0;
        gap_bits = 2;
        held = 1'b0;
        cycles = 0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = "reset";
        for (int i = 0; i < 64; i++) begin
            a = BUS_BASE + i;
            bus_mem[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        compare("reset issue_ready", 0, issue_ready);
        compare("reset wb_done", 0, wb_done);
        compare("reset bus_req", 0, bus_req);
        rst = 1'b0;

        //////////////////////////////
        begin_test("scratch_widths", 2);
        for (int w = 0; w < 16; w++) begin
            issue_op(1'b0, LS_W, SCR_BASE + 4 * w, rand_bits(32));
        end
        repeat (20) issue_random(0, 1);
        for (int w = 0; w < 2; w++) begin
            a = SCR_BASE + 4 * rand_bits(4);
            foreach (fns[f]) begin
                for (int b = 0; b < 4; b += width_of(fns[f])) begin
                    issue_op(1'b1, fns[f], a + b, '0);
                end
            end
        end
        finish_test();

        begin_test("bus_variable_latency", 2);
        repeat (40) issue_random(1, 2);
        finish_test();

        begin_test("misaligned", 2);
        for (int i = 0; i < 12; i++) begin
            a = (rand_bits(1) ? BUS_BASE : SCR_BASE) + 4 * rand_bits(4);
            if (rand_bits(1)) begin
                issue_op(rand_bits(1), LS_H, a + 1 + 2 * rand_bits(1), rand_bits(32));
            end else begin
                issue_op(rand_bits(1), LS_W, a + 1 + rand_bits(1), rand_bits(32));
            end
            mis_words.push_back(a);
        end
        finish_test();

        // Words hit by the rejected accesses must still hold the model data
        begin_test("misaligned_readback", 2);
        foreach (mis_words[k]) begin
            issue_op(1'b1, LS_W, mis_words[k], '0);
        end
        finish_test();

        begin_test("wb_backpressure", 3);
        repeat (40) issue_random(2, 2);
        finish_test();

        begin_test("unit_switch_order", 0);
        repeat (40) issue_random(2, 0);
        finish_test();

        begin_test("store_ids", 2);
        repeat (30) issue_random(2, 1);
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
//////////////////////////////
// Load/store unit top level.
// Issue stage feeds the scratch memory and the bus port directly,
// load attributes queue in a FIFO and results leave through the
// writeback stage. Memory depth and FIFO depth are set here.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int SCRATCH_WORDS = 256,
    parameter int ATTR_DEPTH    = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 issue_valid,
    input  wire lsu_pkg::ls_issue_t   issue,
    output logic                      issue_ready,
    output lsu_pkg::exception_t       ls_exception,
    output logic                      store_complete,
    output lsu_pkg::id_t              store_id,
    output logic                      wb_done,
    output logic [31:0]               wb_data,
    output lsu_pkg::id_t              wb_id,
    input  wire logic                 wb_ack,
    output logic                      bus_req,
    output logic [31:0]               bus_addr,
    output logic [31:0]               bus_wdata,
    output logic [3:0]                bus_be,
    output logic                      bus_rnw,
    input  wire logic                 bus_ack,
    input  wire logic [31:0]          bus_rdata
);
    import lsu_pkg::*;

    sub_req_t    req;
    load_attr_t  attr_in;
    load_attr_t  attr_out;
    logic        scratch_start;
    logic        bus_start;
    logic        attr_push;
    logic        attr_pop;
    logic        fifo_valid;
    logic        fifo_full;
    logic        done_held;
    logic        bus_busy;
    logic [31:0] scratch_rdata;
    logic        scratch_valid;
    logic [31:0] bus_load_data;
    logic        bus_valid;

    //////////////////////////////
    // Issue side
    ls_request_stage #(
        .ATTR_DEPTH(ATTR_DEPTH)
    ) i_request (
        .clk, .rst, .issue_valid, .issue,
        .fifo_full, .fifo_valid, .done_held, .wb_ack,
        .bus_busy, .issue_ready, .ls_exception, .req,
        .scratch_start, .bus_start, .attr_push, .attr_in,
        .store_complete, .store_id
    );

    load_attr_fifo #(
        .ATTR_DEPTH(ATTR_DEPTH)
    ) i_attr_fifo (
        .clk, .rst, .push(attr_push), .data_in(attr_in), .pop(attr_pop),
        .data_out(attr_out), .valid(fifo_valid), .full(fifo_full)
    );

    //////////////////////////////
    // Sub-units
    scratch_mem #(
        .SCRATCH_WORDS(SCRATCH_WORDS)
    ) i_scratch (
        .clk, .rst, .start(scratch_start), .req,
        .rdata(scratch_rdata), .data_valid(scratch_valid)
    );

    bus_port i_bus (
        .clk, .rst, .start(bus_start), .req, .bus_ack, .bus_rdata,
        .busy(bus_busy), .bus_req, .bus_addr, .bus_wdata, .bus_be,
        .bus_rnw, .rdata(bus_load_data), .data_valid(bus_valid)
    );

    //////////////////////////////
    // Result side
    load_return i_return (
        .clk, .rst, .attr(attr_out),
        .scratch_rdata, .scratch_valid,
        .bus_rdata(bus_load_data), .bus_valid,
        .wb_ack, .attr_pop, .done_held, .wb_done, .wb_data, .wb_id
    );

endmodule

`default_nettype wire

//--- hw/load_return.sv
//////////////////////////////
// Result side of the load/store unit.
// Picks the sub-unit data, aligns the byte or halfword, extends
// it by funct3 and holds the result until writeback acks it.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_return (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire lsu_pkg::load_attr_t  attr,
    input  wire logic [31:0]          scratch_rdata,
    input  wire logic                 scratch_valid,
    input  wire logic [31:0]          bus_rdata,
    input  wire logic                 bus_valid,
    input  wire logic                 wb_ack,
    output logic                      attr_pop,
    output logic                      done_held,
    output logic                      wb_done,
    output logic [31:0]               wb_data,
    output lsu_pkg::id_t              wb_id
);
    import lsu_pkg::*;

    logic [31:0] unit_data;
    logic [31:0] aligned;
    logic [31:0] final_data;
    logic        load_valid;
    logic        done_r;
    logic [31:0] data_r;
    id_t         id_r;

    assign unit_data  = attr.unit ? bus_rdata : scratch_rdata;
    assign load_valid = scratch_valid | bus_valid;

    //////////////////////////////
    // Halfword first, then byte
    always_comb begin
        aligned = unit_data;
        if (attr.byte_addr[1]) begin
            aligned[15:0] = unit_data[31:16];
        end
        if (attr.byte_addr[0]) begin
            aligned[7:0] = aligned[15:8];
        end
    end

    always_comb begin
        case (attr.fn3)
            LS_B:    final_data = {{24{aligned[7]}}, aligned[7:0]};
            LS_H:    final_data = {{16{aligned[15]}}, aligned[15:0]};
            L_BU:    final_data = {24'h000000, aligned[7:0]};
            L_HU:    final_data = {16'h0000, aligned[15:0]};
            default: final_data = aligned;
        endcase
    end

    //////////////////////////////
    // Done register
    always_ff @(posedge clk) begin
        if (rst) begin
            done_r <= 1'b0;
        end else if (wb_ack) begin
            done_r <= 1'b0;
        end else if (load_valid) begin
            done_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid && !wb_ack) begin
            data_r <= final_data;
            id_r   <= attr.id;
        end
    end

    // Writeback slot is occupied, either held or arriving now
    assign done_held = done_r | load_valid;

    assign wb_done  = done_held;
    assign wb_data  = done_r ? data_r : final_data;
    assign wb_id    = done_r ? id_r : attr.id;
    assign attr_pop = wb_ack;

endmodule

`default_nettype wire

//--- hw/bus_port.sv
//////////////////////////////
// External bus master sub-unit.
// Holds a single transaction: the request is registered, bus_req
// strobes for one cycle and the port stays busy until bus_ack.
// Load data is passed straight back in the ack cycle.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_port (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire lsu_pkg::sub_req_t  req,
    input  wire logic               bus_ack,
    input  wire logic [31:0]        bus_rdata,
    output logic                    busy,
    output logic                    bus_req,
    output logic [31:0]             bus_addr,
    output logic [31:0]             bus_wdata,
    output logic [3:0]              bus_be,
    output logic                    bus_rnw,
    output logic [31:0]             rdata,
    output logic                    data_valid
);

    logic ack_seen;

    // Ack only counts while a transaction is open
    assign ack_seen = busy & bus_ack;

    //////////////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bus_req <= 1'b0;
        end else begin
            bus_req <= start;
            if (start) begin
                busy <= 1'b1;
            end else if (ack_seen) begin
                busy <= 1'b0;
            end
        end
    end

    // Address and data held stable until the ack
    always_ff @(posedge clk) begin
        if (start) begin
            bus_addr  <= req.addr;
            bus_wdata <= req.wdata;
            bus_be    <= req.be;
            bus_rnw   <= req.load;
        end
    end

    //////////////////////////////
    // Read return, stores just close the transaction
    assign rdata      = bus_rdata;
    assign data_valid = ack_seen & bus_rnw;

endmodule

`default_nettype wire

//--- hw/scratch_mem.sv
//////////////////////////////
// Local scratch memory sub-unit.
// Stores write on the start edge under byte enables, loads
// return the whole word one cycle later with a data_valid pulse.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module scratch_mem #(
    parameter int SCRATCH_WORDS = 256
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire lsu_pkg::sub_req_t  req,
    output logic [31:0]             rdata,
    output logic                    data_valid
);

    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    logic [31:0]      mem [SCRATCH_WORDS];
    logic [IDX_W-1:0] idx;
    logic             do_write;
    logic             do_read;

    // Only the low word-address bits select a row
    assign idx      = req.addr[IDX_W+1:2];
    assign do_write = start & req.store;
    assign do_read  = start & req.load;

    //////////////////////////////
    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= do_read;
        end
    end

endmodule

`default_nettype wire

//--- hw/load_attr_fifo.sv
//////////////////////////////
// Small synchronous FIFO for the attributes of outstanding loads.
// Pushed at issue, popped when writeback takes the result.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_attr_fifo #(
    parameter int ATTR_DEPTH = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 push,
    input  wire lsu_pkg::load_attr_t  data_in,
    input  wire logic                 pop,
    output lsu_pkg::load_attr_t       data_out,
    output logic                      valid,
    output logic                      full
);
    import lsu_pkg::*;

    localparam int PTR_W = (ATTR_DEPTH > 1) ? $clog2(ATTR_DEPTH) : 1;
    localparam int CNT_W = $clog2(ATTR_DEPTH + 1);

    load_attr_t       slots [ATTR_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(ATTR_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push_ok = push & ~full;
    assign pop_ok  = pop & valid;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            slots[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    assign data_out = slots[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(ATTR_DEPTH));

endmodule

`default_nettype wire

//--- hw/ls_request_stage.sv
//////////////////////////////
// Issue side of the load/store unit.
// Computes the effective address, flags misaligned accesses,
// builds byte enables and lane-replicated store data, picks the
// sub-unit and decides whether the issue port is ready.
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ls_request_stage #(
    parameter int ATTR_DEPTH = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  issue_valid,
    input  wire lsu_pkg::ls_issue_t    issue,
    input  wire logic                  fifo_full,
    input  wire logic                  fifo_valid,
    input  wire logic                  done_held,
    input  wire logic                  wb_ack,
    input  wire logic                  bus_busy,
    output logic                       issue_ready,
    output lsu_pkg::exception_t        ls_exception,
    output lsu_pkg::sub_req_t          req,
    output logic                       scratch_start,
    output logic                       bus_start,
    output logic                       attr_push,
    output lsu_pkg::load_attr_t        attr_in,
    output logic                       store_complete,
    output lsu_pkg::id_t               store_id
);
    import lsu_pkg::*;

    // With one slot the full flag already blocks any second load
    localparam bit TRACK_UNIT = (ATTR_DEPTH > 1);

    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        unaligned;
    logic        target_bus;
    logic        last_unit;
    logic        unit_stall;
    logic        accept;
    logic        mem_op;

    assign addr = issue.rs1 + {{20{issue.offset[11]}}, issue.offset};

    //////////////////////////////
    // Alignment check
    always_comb begin
        case (issue.fn3)
            LS_H, L_HU: unaligned = addr[0];
            LS_W:       unaligned = |addr[1:0];
            default:    unaligned = 1'b0;
        endcase
    end

    // Byte enables for stores only, data copied to every lane
    always_comb begin
        be = 4'b0000;
        case (issue.fn3[1:0])
            2'b00: begin
                be[addr[1:0]] = 1'b1;
                wdata = {4{issue.rs2[7:0]}};
            end
            2'b01: begin
                be[{addr[1], 1'b0}] = 1'b1;
                be[{addr[1], 1'b1}] = 1'b1;
                wdata = {2{issue.rs2[15:0]}};
            end
            default: begin
                be = 4'b1111;
                wdata = issue.rs2;
            end
        endcase
        be = be & {4{issue.store}};
    end

    //////////////////////////////
    // Unit selection and switch stall
    assign target_bus = (addr[31:28] != SCRATCH_REGION);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_unit <= 1'b0;
        end else if (attr_push) begin
            last_unit <= target_bus;
        end
    end

    // Results must come back in order, so wait for the FIFO to drain
    assign unit_stall = TRACK_UNIT && fifo_valid && (target_bus != last_unit);

    assign issue_ready = ~rst & ~fifo_full & ~bus_busy & ~unit_stall
                       & (~done_held | wb_ack);

    assign accept = issue_valid & issue_ready;
    assign mem_op = accept & ~unaligned & (issue.load | issue.store);

    //////////////////////////////
    // Outputs
    assign req.addr  = addr;
    assign req.wdata = wdata;
    assign req.be    = be;
    assign req.load  = issue.load;
    assign req.store = issue.store;
    assign req.fn3   = issue.fn3;

    assign scratch_start = mem_op & ~target_bus;
    assign bus_start     = mem_op & target_bus;

    assign attr_push         = mem_op & issue.load;
    assign attr_in.fn3       = issue.fn3;
    assign attr_in.byte_addr = addr[1:0];
    assign attr_in.id        = issue.id;
    assign attr_in.unit      = target_bus;

    assign store_complete = mem_op & issue.store;
    assign store_id       = issue.id;

    assign ls_exception.valid = accept & unaligned & (issue.load | issue.store);
    assign ls_exception.code  = issue.store ? STORE_MISALIGNED : LOAD_MISALIGNED;
    assign ls_exception.tval  = addr;
    assign ls_exception.id    = issue.id;

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
//////////////////////////////
// Shared types and constants for the load/store unit.
// Issue packet, exception packet, sub-unit request and the
// attributes kept for each outstanding load, plus the funct3
// width codes and the address map.
//////////////////////////////

`default_nettype none

package lsu_pkg;

    // Instruction tag
    typedef logic [2:0] id_t;

    // RISC-V funct3 width codes
    localparam logic [2:0] LS_B = 3'b000;
    localparam logic [2:0] LS_H = 3'b001;
    localparam logic [2:0] LS_W = 3'b010;
    localparam logic [2:0] L_BU = 3'b100;
    localparam logic [2:0] L_HU = 3'b101;

    // Exception causes
    localparam logic [4:0] LOAD_MISALIGNED  = 5'd4;
    localparam logic [4:0] STORE_MISALIGNED = 5'd6;

    // Top nibble of every scratch address, all else is bus
    localparam logic [3:0] SCRATCH_REGION = 4'h0;

    typedef struct packed {
        logic [31:0] rs1;
        logic [11:0] offset;
        logic [31:0] rs2;
        logic [2:0]  fn3;
        logic        load;
        logic        store;
        id_t         id;
    } ls_issue_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        load;
        logic        store;
        logic [2:0]  fn3;
    } sub_req_t;

    // unit is 0 for scratch, 1 for bus
    typedef struct packed {
        logic [2:0] fn3;
        logic [1:0] byte_addr;
        id_t        id;
        logic       unit;
    } load_attr_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  code;
        logic [31:0] tval;
        id_t         id;
    } exception_t;

endpackage

`default_nettype wire
